// File: src/fm_consts.svh
/*
 FM phase generator constants
 Slot count, pipeline depths and register addresses
*/
`ifndef FM_CONSTS_SVH
`define FM_CONSTS_SVH

// Operator slots in the round-robin
`define FM_SLOTS     8
`define FM_SLOT_W    3

// Stages between the calculator and the stream outputs
`define FM_OUT_DELAY 2

// Register space
`define FM_ADDR_W    6
`define FM_REG_STOP  6'h20

`endif

// File: src/fm_pkg.sv
/*
 FM phase generator types
 Slot settings, phase widths and the output pad payload
*/
`include "fm_consts.svh"

package fm_pkg;

	// Slot index, visited in round-robin
	typedef logic [`FM_SLOT_W-1:0] slot_t;

	// Frequency number and octave
	typedef logic [10:0] fnum_t;
	typedef logic [2:0]  block_t;

	// Multiplier, 0 means one half
	typedef logic [3:0] mul_t;

	// Detune, sign over a two bit magnitude
	typedef struct packed {
		logic       sign;
		logic [1:0] mag;
	} dt_t;

	// Octave plus two note bits
	typedef logic [4:0] keycode_t;

	// Accumulator and the slice sent out
	typedef logic [19:0] phase_acc_t;
	typedef logic [9:0]  phase_out_t;

	// Byte wide register bus
	typedef logic [7:0] wb_data_t;

	// Slot and phase travelling through the output pad
	typedef struct packed {
		slot_t      slot;
		phase_out_t phase;
	} pad_t;

endpackage

// File: src/fm_shreg.sv
/*
 Shift register with asynchronous clear
 DEPTH stages of any packed payload type
*/
`timescale 1ns/1ps

module fm_shreg #(
	parameter type T     = logic,
	parameter int  DEPTH = 1
) (
	input  logic clk,
	input  logic rst_n,
	input  T     din,
	output T     dout
);

	// Stage 0 takes din, last stage drives dout
	T sr [DEPTH];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				sr[i] <= '0;
			end
		end else begin
			sr[0] <= din;
			// One step per clock
			for (int i = 1; i < DEPTH; i++) begin
				sr[i] <= sr[i-1];
			end
		end
	end

	assign dout = sr[DEPTH-1];

endmodule

// File: src/fm_pg_calc.sv
/*
 FM phase calculator
 Combinational keycode, detune, multiplier and accumulator update
 for the slot in stage II
*/
`timescale 1ns/1ps

module fm_pg_calc (
	input  fm_pkg::fnum_t      fnum,
	input  fm_pkg::block_t     block,
	input  fm_pkg::mul_t       mul,
	input  fm_pkg::dt_t        dt,
	input  logic               pg_rst,
	input  logic               pg_stop,
	input  fm_pkg::phase_acc_t phase_in,
	output fm_pkg::phase_acc_t phase_out,
	output fm_pkg::keycode_t   keycode
);
	import fm_pkg::*;

	logic       kc_lsb;
	keycode_t   kc;
	phase_acc_t base;
	phase_acc_t kc_scale;
	phase_acc_t dt_off;
	phase_acc_t detuned;
	phase_acc_t inc;

	// Note bit rounds fnum into four bands per octave
	// Upper half of the fnum range rounds up from 0x480
	always_comb begin
		if (fnum[10]) begin
			kc_lsb = fnum[9] | fnum[8] | fnum[7];
		end else begin
			kc_lsb = fnum[9] & fnum[8] & fnum[7];
		end
	end

	assign kc      = {block, fnum[10], kc_lsb};
	assign keycode = kc;

	// Octave shift, then halve
	// Top octave with full fnum still fits in 17 bits
	assign base = (phase_acc_t'(fnum) << block) >> 1;

	// Simplified detune, grows with the octave part of the keycode
	assign kc_scale = phase_acc_t'(kc[4:2]) + 20'd1;
	assign dt_off   = phase_acc_t'(dt.mag) * kc_scale;

	// Sign bit picks direction
	// Negative detune near zero wraps around 2^20
	always_comb begin
		if (dt.sign) begin
			detuned = base - dt_off;
		end else begin
			detuned = base + dt_off;
		end
	end

	// Multiplier stage, zero stands for x0.5
	always_comb begin
		if (mul == '0) begin
			inc = detuned >> 1;
		end else begin
			inc = detuned * phase_acc_t'(mul);
		end
	end

	// Visit rule
	// key-on reset wins over stop
	always_comb begin
		if (pg_rst) begin
			phase_out = '0;
		end else if (pg_stop) begin
			phase_out = phase_in;
		end else begin
			phase_out = phase_in + inc;
		end
	end

endmodule

// File: src/fm_slot_regs.sv
/*
 FM slot register file
 Wishbone classic slave for the slot settings, key-on flags and stop,
 plus the round-robin sequencer that issues one slot per cycle
*/
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_slot_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  logic [`FM_ADDR_W-1:0] adr,
	input  fm_pkg::wb_data_t      dat_w,
	output fm_pkg::wb_data_t      dat_r,
	output logic                  ack,
	output fm_pkg::slot_t         issue_slot,
	output fm_pkg::fnum_t         fnum,
	output fm_pkg::block_t        block,
	output fm_pkg::mul_t          mul,
	output fm_pkg::dt_t           dt,
	output logic                  pg_rst,
	output logic                  pg_stop
);
	import fm_pkg::*;

	fnum_t               fnum_r  [`FM_SLOTS];
	block_t              block_r [`FM_SLOTS];
	mul_t                mul_r   [`FM_SLOTS];
	dt_t                 dt_r    [`FM_SLOTS];
	logic [`FM_SLOTS-1:0] pend;
	logic                stop_q;
	slot_t               slot_q;

	logic     bus_req;
	logic     bus_wr;
	logic     is_slot;
	logic     is_stop;
	slot_t    reg_slot;
	logic [1:0] field;
	logic     kon_wr;
	wb_data_t rd_data;

	// New request only while ack is low, so each cycle is taken once
	assign bus_req  = cyc & stb & ~ack;
	assign bus_wr   = bus_req & we;
	assign is_slot  = adr < `FM_REG_STOP;
	assign is_stop  = adr == `FM_REG_STOP;
	assign reg_slot = adr[`FM_SLOT_W+1:2];
	assign field    = adr[1:0];
	assign kon_wr   = bus_wr & is_slot & (field == 2'd3) & dat_w[0];

	// Read mux, key-on field reads back as zero
	always_comb begin
		rd_data = '0;
		if (is_stop) begin
			rd_data = {7'd0, stop_q};
		end else if (is_slot) begin
			case (field)
				2'd0: rd_data = fnum_r[reg_slot][7:0];
				2'd1: rd_data = {2'd0, block_r[reg_slot], fnum_r[reg_slot][10:8]};
				2'd2: rd_data = {1'b0, dt_r[reg_slot], mul_r[reg_slot]};
				default: rd_data = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `FM_SLOTS; i++) begin
				fnum_r[i]  <= '0;
				block_r[i] <= '0;
				mul_r[i]   <= '0;
				dt_r[i]    <= '0;
			end
			pend       <= '0;
			stop_q     <= 1'b0;
			slot_q     <= '0;
			ack        <= 1'b0;
			dat_r      <= '0;
			issue_slot <= '0;
			fnum       <= '0;
			block      <= '0;
			mul        <= '0;
			dt         <= '0;
			pg_rst     <= 1'b0;
			pg_stop    <= 1'b0;
		end else begin
			// Bus side, write lands on the edge that raises ack
			ack <= bus_req;
			if (bus_req) begin
				dat_r <= rd_data;
			end
			if (bus_wr && is_slot) begin
				case (field)
					2'd0: fnum_r[reg_slot][7:0] <= dat_w;
					2'd1: begin
						block_r[reg_slot]      <= dat_w[5:3];
						fnum_r[reg_slot][10:8] <= dat_w[2:0];
					end
					2'd2: begin
						dt_r[reg_slot]  <= dat_w[6:4];
						mul_r[reg_slot] <= dat_w[3:0];
					end
					default: ;
				endcase
			end
			if (bus_wr && is_stop) begin
				stop_q <= dat_w[0];
			end

			// Pending flag clears as it is issued
			// A key-on for the slot issued now waits for the next visit
			for (int i = 0; i < `FM_SLOTS; i++) begin
				if (kon_wr && reg_slot == slot_t'(i)) begin
					pend[i] <= 1'b1;
				end else if (slot_q == slot_t'(i)) begin
					pend[i] <= 1'b0;
				end
			end

			// Issue the visited slot
			issue_slot <= slot_q;
			fnum       <= fnum_r[slot_q];
			block      <= block_r[slot_q];
			mul        <= mul_r[slot_q];
			dt         <= dt_r[slot_q];
			pg_rst     <= pend[slot_q];
			pg_stop    <= stop_q;

			if (slot_q == slot_t'(`FM_SLOTS - 1)) begin
				slot_q <= '0;
			end else begin
				slot_q <= slot_q + 1'b1;
			end
		end
	end

endmodule

// File: src/fm_pg.sv
/*
 FM phase generator stage
 Stage II registers, the circulating phase accumulator ring and
 the output pad for the phase stream
*/
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_pg (
	input  logic               clk,
	input  logic               rst_n,
	input  fm_pkg::slot_t      issue_slot,
	input  fm_pkg::fnum_t      fnum,
	input  fm_pkg::block_t     block,
	input  fm_pkg::mul_t       mul,
	input  fm_pkg::dt_t        dt,
	input  logic               pg_rst,
	input  logic               pg_stop,
	output fm_pkg::phase_out_t phase,
	output fm_pkg::slot_t      out_slot,
	output logic               out_valid
);
	import fm_pkg::*;

	slot_t      slot_ii;
	fnum_t      fnum_ii;
	block_t     block_ii;
	mul_t       mul_ii;
	dt_t        dt_ii;
	logic       rst_ii;
	logic       stop_ii;

	phase_acc_t phase_ring;
	phase_acc_t phase_next;
	phase_acc_t acc_q;
	pad_t       pad_in;
	pad_t       pad_out;
	logic [2:0] fill;

	// Stage II, one cycle after issue
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_ii  <= '0;
			fnum_ii  <= '0;
			block_ii <= '0;
			mul_ii   <= '0;
			dt_ii    <= '0;
			rst_ii   <= 1'b0;
			stop_ii  <= 1'b0;
		end else begin
			slot_ii  <= issue_slot;
			fnum_ii  <= fnum;
			block_ii <= block;
			mul_ii   <= mul;
			dt_ii    <= dt;
			rst_ii   <= pg_rst;
			stop_ii  <= pg_stop;
		end
	end

	// Keycode not needed past the detune in this design
	fm_pg_calc u_calc (
		.fnum      (fnum_ii),
		.block     (block_ii),
		.mul       (mul_ii),
		.dt        (dt_ii),
		.pg_rst    (rst_ii),
		.pg_stop   (stop_ii),
		.phase_in  (phase_ring),
		.phase_out (phase_next),
		.keycode   ()
	);

	// acc_q plus FM_SLOTS-1 ring stages
	// each slot's phase meets the adder again on its next visit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q <= '0;
		end else begin
			acc_q <= phase_next;
		end
	end

	fm_shreg #(.T(phase_acc_t), .DEPTH(`FM_SLOTS - 1)) u_acc (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (acc_q),
		.dout  (phase_ring)
	);

	// Top ten bits with their slot number
	assign pad_in = '{slot: slot_ii, phase: phase_next[19:10]};

	fm_shreg #(.T(pad_t), .DEPTH(`FM_OUT_DELAY - 1)) u_pad (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (pad_in),
		.dout  (pad_out)
	);

	// Output register, last pad stage
	// fill counts issue, stage II, pad and output edges
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase    <= '0;
			out_slot <= '0;
			fill     <= '0;
		end else begin
			phase    <= pad_out.phase;
			out_slot <= pad_out.slot;
			if (fill != 3'(`FM_OUT_DELAY + 2)) begin
				fill <= fill + 1'b1;
			end
		end
	end

	assign out_valid = fill == 3'(`FM_OUT_DELAY + 2);

endmodule

// File: src/fm_phase_top.sv
/*
 FM operator phase generator
 Wishbone slot registers feeding the time-multiplexed phase stage
*/
`timescale 1ns/1ps
`include "fm_consts.svh"

module fm_phase_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  logic [`FM_ADDR_W-1:0] adr,
	input  fm_pkg::wb_data_t      dat_w,
	output fm_pkg::wb_data_t      dat_r,
	output logic                  ack,
	output fm_pkg::phase_out_t    phase,
	output fm_pkg::slot_t         out_slot,
	output logic                  out_valid
);
	import fm_pkg::*;

	// Issue bus, one slot per cycle
	slot_t  issue_slot;
	fnum_t  fnum;
	block_t block;
	mul_t   mul;
	dt_t    dt;
	logic   pg_rst;
	logic   pg_stop;

	fm_slot_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.dat_r      (dat_r),
		.ack        (ack),
		.issue_slot (issue_slot),
		.fnum       (fnum),
		.block      (block),
		.mul        (mul),
		.dt         (dt),
		.pg_rst     (pg_rst),
		.pg_stop    (pg_stop)
	);

	fm_pg u_pg (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue_slot (issue_slot),
		.fnum       (fnum),
		.block      (block),
		.mul        (mul),
		.dt         (dt),
		.pg_rst     (pg_rst),
		.pg_stop    (pg_stop),
		.phase      (phase),
		.out_slot   (out_slot),
		.out_valid  (out_valid)
	);

endmodule

// File: tests/fm_phase_sva.sv
/*
 FM phase generator protocol assertions
 Wishbone ack shape and the slot order of the phase stream
*/
`timescale 1ns/1ps

module fm_phase_sva (
	input logic          clk,
	input logic          rst_n,
	input logic          cyc,
	input logic          stb,
	input logic          ack,
	input fm_pkg::slot_t out_slot,
	input logic          out_valid
);

	// Ack is a single cycle pulse
	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack)
		else $error("ack held for more than one cycle");

	// Ack only answers a strobed bus cycle
	a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> $past(cyc && stb))
		else $error("ack without a preceding cyc and stb");

	// Round-robin order on the stream
	a_slot_step: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && $past(out_valid)) |-> (out_slot == 3'($past(out_slot) + 3'd1)))
		else $error("out_slot skipped a slot");

	// Stream stays valid once started
	a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> out_valid)
		else $error("out_valid dropped");

endmodule

bind fm_phase_top fm_phase_sva u_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.cyc       (cyc),
	.stb       (stb),
	.ack       (ack),
	.out_slot  (out_slot),
	.out_valid (out_valid)
);

// File: tests/fm_phase_tb.sv
/*
 FM phase generator testbench
 Runs the command file over Wishbone and checks the phase stream
*/
`timescale 1ns/1ps

module fm_phase_tb;

	logic       clk;
	logic       rst_n;
	logic       cyc;
	logic       stb;
	logic       we;
	logic [5:0] adr;
	logic [7:0] dat_w;
	logic [7:0] dat_r;
	logic       ack;
	logic [9:0] phase;
	logic [2:0] out_slot;
	logic       out_valid;

	int    cyc_cnt;
	int    limit;
	int    ack_cnt;
	string lines[$];

	fm_phase_top i_fm_phase_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.dat_r     (dat_r),
		.ack       (ack),
		.phase     (phase),
		.out_slot  (out_slot),
		.out_valid (out_valid)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	// Cycle counter that also bounds the run
	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (limit > 0 && cyc_cnt > limit) begin
			$display("Timeout: the run went past %0d cycles without finishing", limit);
			$display("Simulation failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "value check failed");
		end
	endtask

	// One Wishbone classic cycle that returns once ack is seen
	task automatic bus_access(input bit write, input logic [5:0] a, input logic [7:0] d,
			output logic [7:0] rd);
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= write;
		adr   <= a;
		dat_w <= d;
		do begin
			@(negedge clk);
		end while (!ack);
		rd      = dat_r;
		ack_cnt = cyc_cnt;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	// Follow one slot's visits and check the phase after a number of them
	// Key-on mode counts from the reset visit, otherwise from the first nonzero phase
	task automatic follow_slot(input int slot, input int visits, input logic [9:0] exp,
			input bit keyon);
		int  seen;
		bit  done;
		seen = -1;
		done = 0;
		while (!done) begin
			@(negedge clk);
			// Outputs up to 3 edges past the ack edge still come from older issues
			if (out_valid && out_slot == 3'(slot) && cyc_cnt >= ack_cnt + 4) begin
				if (seen < 0) begin
					if (keyon) begin
						check($sformatf("phase slot %0d at key-on", slot), 32'd0,
							32'(phase));
						seen = 0;
					end else if (phase != 0) begin
						seen = 1;
					end
				end else begin
					seen++;
				end
				if (seen == visits) begin
					check($sformatf("phase slot %0d visit %0d", slot, visits), 32'(exp),
						32'(phase));
					done = 1;
				end
			end
		end
	endtask

	// With stop set, every slot repeats its phase round after round
	task automatic check_hold();
		logic [9:0] held [8];
		int         n;
		repeat (24) @(negedge clk);
		n = 0;
		while (n < 8) begin
			@(negedge clk);
			if (out_valid) begin
				held[out_slot] = phase;
				n++;
			end
		end
		n = 0;
		while (n < 8) begin
			@(negedge clk);
			if (out_valid) begin
				check($sformatf("held phase slot %0d", out_slot), 32'(held[out_slot]),
					32'(phase));
				n++;
			end
		end
	endtask

	initial begin
		int          fd;
		string       line;
		string       cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [7:0]  rd;
		clk     = 1'b0;
		rst_n   = 1'b0;
		cyc     = 1'b0;
		stb     = 1'b0;
		we      = 1'b0;
		adr     = '0;
		dat_w   = '0;
		cyc_cnt = 0;
		limit   = 0;
		ack_cnt = 0;

		fd = $fopen("tests/fm_phase_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file tests/fm_phase_tests.txt");
			$display("Simulation failed");
			$fatal(1, "missing data file");
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) != 0) begin
				lines.push_back(line);
			end
		end
		$fclose(fd);
		limit = 64 * lines.size() + 200;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// Stream fills through issue, stage II, pad and output edges
		repeat (4) begin
			@(negedge clk);
			check("out_valid", 32'd0, 32'(out_valid));
			check("ack", 32'd0, 32'(ack));
		end
		@(negedge clk);
		check("out_valid", 32'd1, 32'(out_valid));

		foreach (lines[i]) begin
			line = lines[i];
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			a = 0;
			b = 0;
			c = 0;
			void'($sscanf(line, "%s %h %h %h", cmd, a, b, c));
			case (cmd)
				"W": bus_access(1'b1, a[5:0], b[7:0], rd);
				"R": begin
					bus_access(1'b0, a[5:0], 8'h00, rd);
					check($sformatf("dat_r at 0x%02h", a[5:0]), 32'(b[7:0]), 32'(rd));
				end
				"K": begin
					bus_access(1'b1, 6'(a * 4 + 3), 8'h01, rd);
					follow_slot(a, b, c[9:0], 1'b1);
				end
				"C": follow_slot(a, b, c[9:0], 1'b0);
				"S": begin
					bus_access(1'b1, 6'h20, {7'd0, a[0]}, rd);
					if (a[0]) begin
						check_hold();
					end
				end
				default: begin
					$display("Unknown command in the test data file: %s", line);
					$display("Simulation failed");
					$fatal(1, "bad data file");
				end
			endcase
		end

		repeat (4) @(posedge clk);
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: tests/fm_phase_tests.txt
# Columns, all hex: W addr data | R addr expected | K slot visits phase
# C slot visits phase (counted from the first nonzero phase) | S stop
W 04 34
W 05 1a
W 06 25
W 07 01
R 04 34
R 05 1a
R 06 25
R 07 00
R 20 00
W 00 00
W 01 22
W 02 01
K 0 3 00c
K 1 4 02c
W 08 ff
W 09 3f
W 0a 00
K 2 5 13f
W 0c 80
W 0d 34
W 0e 37
K 3 5 0ec
W 10 00
W 11 00
W 12 71
K 4 2 3ff
W 14 a0
W 15 2d
W 16 63
K 5 4 10d
K 0 3 00c
W 18 00
W 19 29
W 1a 02
S 1
K 6 3 000
S 0
C 6 3 018

// File: files.f
+incdir+src
src/fm_pkg.sv
src/fm_shreg.sv
src/fm_pg_calc.sv
src/fm_slot_regs.sv
src/fm_pg.sv
src/fm_phase_top.sv
tests/fm_phase_sva.sv
tests/fm_phase_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FM phase generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f files.f \
	--top-module fm_phase_tb \
	-o fm_phase_sim

./obj_dir/fm_phase_sim > sim.log 2>&1

cat sim.log

if grep -q "Simulation passed" sim.log; then
	exit 0
fi
exit 1
